// File: design/umi_settings.svh
`ifndef UMI_SETTINGS_SVH
`define UMI_SETTINGS_SVH

// Width of the packet data field
`define UMI_DW 64

// Memory target depth in 64-bit words
`define UMI_MEM_WORDS 256

// Destination address bit that selects the CSR bank over the memory
`define UMI_CSR_BASE_BIT 31

// Register offsets inside the CSR bank
`define UMI_CSR_ID_OFF       32'h0000_0000
`define UMI_CSR_SCRATCH0_OFF 32'h0000_0008
`define UMI_CSR_SCRATCH1_OFF 32'h0000_0010
`define UMI_CSR_WCOUNT_OFF   32'h0000_0018

// Read-only identity value
`define UMI_EP_ID 64'h554d_4945_5030_0001

`endif

// File: design/umi_pkg.sv
`include "umi_settings.svh"

package umi_pkg;

	// Command opcodes carried in the low nibble
	typedef enum logic [3:0] {
		REQ_READ   = 4'h1,
		RESP_READ  = 4'h2,
		REQ_WRITE  = 4'h3,
		RESP_WRITE = 4'h4,
		REQ_POSTED = 4'h5
	} umi_opcode_e;

	typedef enum logic [1:0] {
		STATUS_OK  = 2'b00,
		STATUS_ERR = 2'b10
	} umi_status_e;

	// Request view of the command word
	typedef struct packed {
		logic [19:0] rsvd;
		logic [7:0]  tag;
		umi_opcode_e opcode;
	} umi_req_cmd_t;

	// Response view of the command word
	// Tag stays at the same bits as in a request
	typedef struct packed {
		logic [17:0] rsvd;
		umi_status_e status;
		logic [7:0]  tag;
		umi_opcode_e opcode;
	} umi_resp_cmd_t;

	// Read as a request on RX, written as a response on TX
	typedef union packed {
		umi_req_cmd_t  req;
		umi_resp_cmd_t resp;
	} umi_cmd_u;

	// Full 256-bit packet, most significant field first
	typedef struct packed {
		logic [63:0]        rsvd_hi;
		logic [`UMI_DW-1:0] data;
		logic [31:0]        srcaddr;
		logic [31:0]        dstaddr;
		logic [31:0]        rsvd_lo;
		umi_cmd_u           cmd;
	} umi_packet_t;

endpackage

// File: design/ep_pkg.sv
`include "umi_settings.svh"

package ep_pkg;

	// Request handed from the decoder to one target
	// Offset has the CSR select bit already cleared
	typedef struct packed {
		logic               write;
		logic [31:0]        offset;
		logic [`UMI_DW-1:0] data;
		logic [7:0]         tag;
	} tgt_req_t;

	// Target reply before it is turned into a TX packet
	typedef struct packed {
		logic                 write;
		umi_pkg::umi_status_e status;
		logic [`UMI_DW-1:0]   data;
		logic [7:0]           tag;
	} tgt_resp_t;

endpackage

// File: design/umi_req_decoder.sv
`include "umi_settings.svh"

module umi_req_decoder (
	input  logic                 clk,
	input  logic                 rst_n,
	input  umi_pkg::umi_packet_t umi_packet_rx,
	input  logic                 umi_valid_rx,
	output logic                 umi_ready_rx,
	input  logic                 resp_busy,
	output logic                 mem_req_valid,
	output logic                 csr_req_valid,
	output logic                 resp_pend,
	output ep_pkg::tgt_req_t     tgt_req,
	output logic [31:0]          resp_srcaddr,
	output logic [31:0]          resp_dstaddr
);
	import umi_pkg::*;

	umi_packet_t  pkt_q;
	umi_req_cmd_t cmd;
	logic         accept;
	logic         pend_q;
	logic         csr_sel;
	logic         is_write;
	logic         is_posted;

	assign accept = umi_valid_rx && umi_ready_rx;

	// Held until the next acceptance, which waits for the reply
	always_ff @(posedge clk) begin
		if (accept) begin
			pkt_q <= umi_packet_rx;
		end
	end

	assign cmd     = pkt_q.cmd.req;
	assign csr_sel = pkt_q.dstaddr[`UMI_CSR_BASE_BIT];

	// Anything that is not a write is served as a read
	assign is_posted = (cmd.opcode == REQ_POSTED);
	assign is_write  = (cmd.opcode == REQ_WRITE) || is_posted;

	always_comb begin
		tgt_req.write  = is_write;
		tgt_req.offset = pkt_q.dstaddr;
		tgt_req.offset[`UMI_CSR_BASE_BIT] = 1'b0;
		tgt_req.data   = pkt_q.data;
		tgt_req.tag    = cmd.tag;
	end

	assign resp_srcaddr = pkt_q.srcaddr;
	assign resp_dstaddr = pkt_q.dstaddr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			umi_ready_rx  <= 1'b1;
			pend_q        <= 1'b0;
			mem_req_valid <= 1'b0;
			csr_req_valid <= 1'b0;
			resp_pend     <= 1'b0;
		end else begin
			pend_q        <= accept;
			mem_req_valid <= pend_q && !csr_sel;
			csr_req_valid <= pend_q && csr_sel;
			// Marks a request whose reply must reach TX
			resp_pend     <= pend_q && !is_posted;
			// Posted writes reopen right after the strobe
			if (accept) begin
				umi_ready_rx <= 1'b0;
			end else if (!pend_q && !resp_busy) begin
				umi_ready_rx <= 1'b1;
			end
		end
	end

	// One target per request, and only while RX is held off
	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req_valid || csr_req_valid) |->
			!(mem_req_valid && csr_req_valid) && !umi_ready_rx);

endmodule

// File: design/umi_mem_target.sv
`include "umi_settings.svh"

module umi_mem_target (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  ep_pkg::tgt_req_t  req,
	output logic              resp_valid,
	output ep_pkg::tgt_resp_t resp
);
	import umi_pkg::*;

	localparam int IDX_W = $clog2(`UMI_MEM_WORDS);

	logic [`UMI_DW-1:0] mem [`UMI_MEM_WORDS];
	logic [IDX_W-1:0]   idx;
	logic               in_range;

	// Byte offset to word index
	// The low three bits pick a byte within the word and are ignored
	assign idx      = req.offset[IDX_W+2:3];
	assign in_range = (req.offset >> 3) < `UMI_MEM_WORDS;

	// Out of range writes are dropped
	always_ff @(posedge clk) begin
		if (req_valid && req.write && in_range) begin
			mem[idx] <= req.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			resp.write  <= req.write;
			resp.status <= in_range ? STATUS_OK : STATUS_ERR;
			resp.data   <= (in_range && !req.write) ? mem[idx] : '0;
			resp.tag    <= req.tag;
		end
	end

	// Reply one cycle after each request, carrying that request's tag
	assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |=> resp_valid && (resp.tag == $past(req.tag)));

endmodule

// File: design/umi_csr_target.sv
`include "umi_settings.svh"

module umi_csr_target (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  ep_pkg::tgt_req_t  req,
	output logic              resp_valid,
	output ep_pkg::tgt_resp_t resp
);
	import umi_pkg::*;

	logic [`UMI_DW-1:0] scratch0;
	logic [`UMI_DW-1:0] scratch1;
	logic [`UMI_DW-1:0] wcount;
	logic [`UMI_DW-1:0] rd_data;
	logic               legal;
	logic               wr_ok;

	// Register map and access rules
	always_comb begin
		rd_data = '0;
		legal   = 1'b1;
		case (req.offset)
			`UMI_CSR_ID_OFF: begin
				rd_data = `UMI_EP_ID;
				legal   = !req.write;
			end
			`UMI_CSR_SCRATCH0_OFF: rd_data = scratch0;
			`UMI_CSR_SCRATCH1_OFF: rd_data = scratch1;
			`UMI_CSR_WCOUNT_OFF: begin
				rd_data = wcount;
				legal   = !req.write;
			end
			default: legal = 1'b0;
		endcase
	end

	assign wr_ok = req_valid && req.write && legal;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scratch0   <= '0;
			scratch1   <= '0;
			wcount     <= '0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= req_valid;
			if (wr_ok) begin
				// Posted writes count as well
				wcount <= wcount + 1'b1;
				if (req.offset == `UMI_CSR_SCRATCH0_OFF) begin
					scratch0 <= req.data;
				end
				if (req.offset == `UMI_CSR_SCRATCH1_OFF) begin
					scratch1 <= req.data;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			resp.write  <= req.write;
			resp.status <= legal ? STATUS_OK : STATUS_ERR;
			resp.data   <= req.write ? '0 : rd_data;
			resp.tag    <= req.tag;
		end
	end

endmodule

// File: design/umi_resp_merge.sv
module umi_resp_merge (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mem_resp_valid,
	input  ep_pkg::tgt_resp_t    mem_resp,
	input  logic                 csr_resp_valid,
	input  ep_pkg::tgt_resp_t    csr_resp,
	input  logic                 resp_pend,
	input  logic [31:0]          resp_srcaddr,
	input  logic [31:0]          resp_dstaddr,
	output umi_pkg::umi_packet_t umi_packet_tx,
	output logic                 umi_valid_tx,
	input  logic                 umi_ready_tx,
	output logic                 resp_busy
);
	import umi_pkg::*;
	import ep_pkg::*;

	tgt_resp_t   sel;
	umi_packet_t pkt;
	logic        busy_q;
	logic        take;
	logic        tx_done;

	// Posted writes never set busy_q so their replies die here
	assign take    = (mem_resp_valid || csr_resp_valid) && busy_q;
	assign tx_done = umi_valid_tx && umi_ready_tx;
	assign sel     = mem_resp_valid ? mem_resp : csr_resp;

	always_comb begin
		pkt                 = '0;
		pkt.cmd.resp.opcode = sel.write ? RESP_WRITE : RESP_READ;
		pkt.cmd.resp.status = sel.status;
		pkt.cmd.resp.tag    = sel.tag;
		pkt.data            = sel.write ? '0 : sel.data;
		// Reply heads back to the requester
		pkt.srcaddr         = resp_dstaddr;
		pkt.dstaddr         = resp_srcaddr;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q       <= 1'b0;
			umi_valid_tx <= 1'b0;
		end else begin
			if (resp_pend) begin
				busy_q <= 1'b1;
			end else if (tx_done) begin
				busy_q <= 1'b0;
			end
			if (take) begin
				umi_valid_tx <= 1'b1;
			end else if (tx_done) begin
				umi_valid_tx <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			umi_packet_tx <= pkt;
		end
	end

	// Pending pulse covers the gap before busy_q is set
	assign resp_busy = busy_q || resp_pend;

	assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_resp_valid && csr_resp_valid));

	// Packet held steady under TX back-pressure
	assert property (@(posedge clk) disable iff (!rst_n)
		umi_valid_tx && !umi_ready_tx |=> umi_valid_tx && $stable(umi_packet_tx));

endmodule

// File: design/umi_endpoint.sv
module umi_endpoint (
	input  logic                 clk,
	input  logic                 rst_n,
	input  umi_pkg::umi_packet_t umi_packet_rx,
	input  logic                 umi_valid_rx,
	output logic                 umi_ready_rx,
	output umi_pkg::umi_packet_t umi_packet_tx,
	output logic                 umi_valid_tx,
	input  logic                 umi_ready_tx
);
	import ep_pkg::*;

	tgt_req_t    tgt_req;
	tgt_resp_t   mem_resp;
	tgt_resp_t   csr_resp;
	logic        mem_req_valid;
	logic        csr_req_valid;
	logic        mem_resp_valid;
	logic        csr_resp_valid;
	logic        resp_pend;
	logic        resp_busy;
	logic [31:0] resp_srcaddr;
	logic [31:0] resp_dstaddr;

	umi_req_decoder u_decoder (
		.clk           (clk),
		.rst_n         (rst_n),
		.umi_packet_rx (umi_packet_rx),
		.umi_valid_rx  (umi_valid_rx),
		.umi_ready_rx  (umi_ready_rx),
		.resp_busy     (resp_busy),
		.mem_req_valid (mem_req_valid),
		.csr_req_valid (csr_req_valid),
		.resp_pend     (resp_pend),
		.tgt_req       (tgt_req),
		.resp_srcaddr  (resp_srcaddr),
		.resp_dstaddr  (resp_dstaddr)
	);

	// Both targets see the same request, only the strobe differs
	umi_mem_target u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (mem_req_valid),
		.req        (tgt_req),
		.resp_valid (mem_resp_valid),
		.resp       (mem_resp)
	);

	umi_csr_target u_csr (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (csr_req_valid),
		.req        (tgt_req),
		.resp_valid (csr_resp_valid),
		.resp       (csr_resp)
	);

	umi_resp_merge u_merge (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp),
		.csr_resp_valid (csr_resp_valid),
		.csr_resp       (csr_resp),
		.resp_pend      (resp_pend),
		.resp_srcaddr   (resp_srcaddr),
		.resp_dstaddr   (resp_dstaddr),
		.umi_packet_tx  (umi_packet_tx),
		.umi_valid_tx   (umi_valid_tx),
		.umi_ready_tx   (umi_ready_tx),
		.resp_busy      (resp_busy)
	);

endmodule

// File: test/umi_endpoint_tb.sv
`include "umi_settings.svh"

module umi_endpoint_tb;
	import umi_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int MEM_PAIRS    = 8;
	localparam int POSTED_PAIRS = 6;
	localparam int CSR_REQS     = 10;
	localparam int ERR_REQS     = 5;
	localparam int FIELD_PAIRS  = 4;
	localparam int FIELD_EXTRA  = 2;
	localparam int BP_PAIRS     = 6;
	localparam int NUM_REQS     = 2 * MEM_PAIRS + 2 * POSTED_PAIRS + CSR_REQS + ERR_REQS
		+ 2 * FIELD_PAIRS + FIELD_EXTRA + 2 * BP_PAIRS;
	localparam int TIMEOUT      = (NUM_REQS * 40 + 200) * CLK_PERIOD;

	logic        clk;
	logic        rst_n;
	umi_packet_t umi_packet_rx;
	logic        umi_valid_rx;
	logic        umi_ready_rx;
	umi_packet_t umi_packet_tx;
	logic        umi_valid_tx;
	logic        umi_ready_tx;

	// Reference model state
	logic [63:0] ref_mem [`UMI_MEM_WORDS];
	logic [63:0] ref_scratch0;
	logic [63:0] ref_scratch1;
	logic [63:0] ref_wcount;

	umi_packet_t exp_q[$];
	umi_packet_t exp_head;
	logic        exp_avail;
	int          ready_pct;
	int          fail_count;
	int          resp_count;
	int          nonposted_count;
	int          tests_passed;
	int          tests_failed;

	umi_endpoint u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.umi_packet_rx (umi_packet_rx),
		.umi_valid_rx  (umi_valid_rx),
		.umi_ready_rx  (umi_ready_rx),
		.umi_packet_tx (umi_packet_tx),
		.umi_valid_tx  (umi_valid_tx),
		.umi_ready_tx  (umi_ready_tx)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic void refresh_head();
		exp_avail = (exp_q.size() > 0);
		if (exp_avail) begin
			exp_head = exp_q[0];
		end
	endfunction

	function automatic logic [31:0] mem_addr(input int idx);
		return 32'(idx) << 3;
	endfunction

	function automatic logic [31:0] csr_addr(input logic [31:0] off);
		return off | (32'h1 << `UMI_CSR_BASE_BIT);
	endfunction

	// Predicts the reply of one request and updates the model
	task automatic model_response(input umi_opcode_e op, input logic [7:0] tag,
		input logic [31:0] src, input logic [31:0] dst, input logic [63:0] data);
		umi_packet_t exp;
		logic        wr;
		logic [31:0] off;
		logic [63:0] rdata;
		umi_status_e st;
		wr    = (op == REQ_WRITE) || (op == REQ_POSTED);
		off   = dst;
		off[`UMI_CSR_BASE_BIT] = 1'b0;
		rdata = '0;
		st    = STATUS_OK;
		if (dst[`UMI_CSR_BASE_BIT]) begin
			case (off)
				`UMI_CSR_ID_OFF: begin
					rdata = `UMI_EP_ID;
					st    = wr ? STATUS_ERR : STATUS_OK;
				end
				`UMI_CSR_SCRATCH0_OFF: begin
					rdata = ref_scratch0;
					ref_scratch0 = wr ? data : ref_scratch0;
				end
				`UMI_CSR_SCRATCH1_OFF: begin
					rdata = ref_scratch1;
					ref_scratch1 = wr ? data : ref_scratch1;
				end
				`UMI_CSR_WCOUNT_OFF: begin
					rdata = ref_wcount;
					st    = wr ? STATUS_ERR : STATUS_OK;
				end
				default: st = STATUS_ERR;
			endcase
			if (wr && st == STATUS_OK) begin
				ref_wcount = ref_wcount + 1;
			end
		end else if ((off >> 3) < `UMI_MEM_WORDS) begin
			rdata = ref_mem[off[10:3]];
			if (wr) begin
				ref_mem[off[10:3]] = data;
			end
		end else begin
			st = STATUS_ERR;
		end
		// Posted writes never answer
		if (op != REQ_POSTED) begin
			exp                 = '0;
			exp.cmd.resp.opcode = wr ? RESP_WRITE : RESP_READ;
			exp.cmd.resp.status = st;
			exp.cmd.resp.tag    = tag;
			exp.data            = wr ? '0 : rdata;
			exp.srcaddr         = dst;
			exp.dstaddr         = src;
			exp_q.push_back(exp);
			nonposted_count++;
			refresh_head();
		end
	endtask

	task automatic drive_request(input umi_opcode_e op, input logic [31:0] dst,
		input logic [63:0] data);
		umi_packet_t pkt;
		int          gap;
		gap = $urandom % 4;
		repeat (gap) @(negedge clk);
		pkt                = '0;
		pkt.cmd.req.opcode = op;
		pkt.cmd.req.tag    = 8'($urandom);
		pkt.srcaddr        = $urandom;
		pkt.dstaddr        = dst;
		pkt.data           = data;
		@(negedge clk);
		umi_packet_rx = pkt;
		umi_valid_rx  = 1'b1;
		model_response(op, pkt.cmd.req.tag, pkt.srcaddr, dst, data);
		// Ready seen here holds through the next rising edge
		while (!umi_ready_rx) @(negedge clk);
		@(negedge clk);
		umi_valid_rx = 1'b0;
	endtask

	task automatic drive_tx_ready();
		forever begin
			@(negedge clk);
			umi_ready_tx = ($urandom % 100) < ready_pct;
		end
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0 || !umi_ready_rx) @(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		wait_idle();
		if (fail_count == errs_before) begin
			$display("test %s: passed", name);
			tests_passed++;
		end else begin
			$display("test %s: failed", name);
			tests_failed++;
		end
	endtask

	always @(posedge clk) begin
		if (rst_n && umi_valid_tx && umi_ready_tx) begin
			if (exp_q.size() > 0) begin
				void'(exp_q.pop_front());
			end
			resp_count++;
			refresh_head();
		end
	end

	// Every TX handshake carries the oldest expected reply
	resp_match: assert property (@(posedge clk) disable iff (!rst_n)
		(umi_valid_tx && umi_ready_tx) |-> (exp_avail && umi_packet_tx == exp_head))
	else begin
		$display("[FAIL] %0t: TX packet %h, expected %h (expected valid %0b)", $time,
			$sampled(umi_packet_tx), $sampled(exp_head), $sampled(exp_avail));
		fail_count++;
	end

	tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(umi_valid_tx && !umi_ready_tx) |=> (umi_valid_tx && $stable(umi_packet_tx)))
	else begin
		$display("[FAIL] %0t: TX packet changed or dropped under back-pressure", $time);
		fail_count++;
	end

	// Acceptance at N gives TX valid after edge N+3
	tx_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(umi_valid_rx && umi_ready_rx && umi_packet_rx.cmd.req.opcode != REQ_POSTED)
		|-> ##4 $rose(umi_valid_tx))
	else begin
		$display("[FAIL] %0t: TX valid did not rise three edges after acceptance", $time);
		fail_count++;
	end

	posted_reopen: assert property (@(posedge clk) disable iff (!rst_n)
		(umi_valid_rx && umi_ready_rx && umi_packet_rx.cmd.req.opcode == REQ_POSTED)
		|-> ##3 umi_ready_rx)
	else begin
		$display("[FAIL] %0t: RX ready not back two edges after a posted write", $time);
		fail_count++;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: the run did not finish within %0d time units", TIMEOUT);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [63:0] val;
		int          errs;
		void'($urandom(32'h4af293ff));
		rst_n           = 1'b0;
		umi_packet_rx   = '0;
		umi_valid_rx    = 1'b0;
		umi_ready_tx    = 1'b1;
		exp_head        = '0;
		exp_avail       = 1'b0;
		ready_pct       = 75;
		fail_count      = 0;
		resp_count      = 0;
		nonposted_count = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		ref_scratch0    = '0;
		ref_scratch1    = '0;
		ref_wcount      = '0;
		fork
			drive_tx_ready();
		join_none
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		errs = fail_count;
		for (int i = 0; i < MEM_PAIRS; i++) begin
			addr = mem_addr($urandom % `UMI_MEM_WORDS);
			val  = {$urandom, $urandom};
			drive_request(REQ_WRITE, addr, val);
			drive_request(REQ_READ, addr, '0);
		end
		report_test("mem_write_read", errs);

		errs = fail_count;
		for (int i = 0; i < POSTED_PAIRS; i++) begin
			addr = mem_addr($urandom % `UMI_MEM_WORDS);
			val  = {$urandom, $urandom};
			drive_request(REQ_POSTED, addr, val);
			drive_request(REQ_READ, addr, '0);
		end
		report_test("posted_write", errs);

		errs = fail_count;
		drive_request(REQ_READ, csr_addr(`UMI_CSR_ID_OFF), '0);
		drive_request(REQ_WRITE, csr_addr(`UMI_CSR_ID_OFF), 64'h1234);
		drive_request(REQ_WRITE, csr_addr(`UMI_CSR_SCRATCH0_OFF), {$urandom, $urandom});
		drive_request(REQ_WRITE, csr_addr(`UMI_CSR_SCRATCH1_OFF), {$urandom, $urandom});
		drive_request(REQ_POSTED, csr_addr(`UMI_CSR_SCRATCH0_OFF), {$urandom, $urandom});
		drive_request(REQ_READ, csr_addr(`UMI_CSR_SCRATCH0_OFF), '0);
		drive_request(REQ_READ, csr_addr(`UMI_CSR_SCRATCH1_OFF), '0);
		drive_request(REQ_READ, csr_addr(`UMI_CSR_WCOUNT_OFF), '0);
		drive_request(REQ_WRITE, csr_addr(`UMI_CSR_WCOUNT_OFF), 64'h55);
		drive_request(REQ_READ, csr_addr(`UMI_CSR_WCOUNT_OFF), '0);
		report_test("csr_bank", errs);

		errs = fail_count;
		drive_request(REQ_READ, mem_addr(`UMI_MEM_WORDS), '0);
		drive_request(REQ_WRITE, 32'h0001_0000, {$urandom, $urandom});
		drive_request(REQ_READ, csr_addr(32'h20), '0);
		drive_request(REQ_WRITE, csr_addr(32'h28), 64'h77);
		drive_request(REQ_POSTED, csr_addr(32'h30), 64'h99);
		report_test("errors", errs);

		errs = fail_count;
		for (int i = 0; i < FIELD_PAIRS; i++) begin
			addr = mem_addr($urandom % `UMI_MEM_WORDS);
			drive_request(REQ_WRITE, addr, {$urandom, $urandom});
			drive_request(REQ_READ, addr, '0);
		end
		// Response opcodes on RX are served as reads
		drive_request(RESP_READ, csr_addr(`UMI_CSR_WCOUNT_OFF), '0);
		drive_request(RESP_WRITE, csr_addr(`UMI_CSR_SCRATCH1_OFF), 64'hdead);
		report_test("resp_fields", errs);

		errs = fail_count;
		ready_pct = 20;
		for (int i = 0; i < BP_PAIRS; i++) begin
			addr = mem_addr($urandom % `UMI_MEM_WORDS);
			drive_request(REQ_WRITE, addr, {$urandom, $urandom});
			drive_request(REQ_READ, addr, '0);
		end
		wait_idle();
		ready_pct = 75;
		repeat (20) @(negedge clk);
		resp_count_check: assert (resp_count == nonposted_count)
		else begin
			$display("[FAIL] %0t: %0d responses for %0d non-posted requests", $time,
				resp_count, nonposted_count);
			fail_count++;
		end
		report_test("back_pressure", errs);

		$display("Summary: %0d tests passed, %0d failed, %0d responses, %0d failed checks",
			tests_passed, tests_failed, resp_count, fail_count);
		if (fail_count == 0 && tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: umi_endpoint.f
+incdir+design
design/umi_pkg.sv
design/ep_pkg.sv
design/umi_req_decoder.sv
design/umi_mem_target.sv
design/umi_csr_target.sv
design/umi_resp_merge.sv
design/umi_endpoint.sv
test/umi_endpoint_tb.sv
